/* sources.f */
+incdir+rtl
rtl/inv_pkg.sv
rtl/index_link_if.sv
rtl/interval_timer.sv
rtl/spi_index_reader.sv
rtl/uart_tx.sv
rtl/inverter_sequencer.sv
rtl/inverter_top.sv
bench/tb_inverter.sv

/* bench/tb_inverter.sv */
// Testbench for the inverter controller with SPI supervisor model and UART lane decoders
`default_nettype none

`include "inv_consts.svh"

module tb_inverter;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [`NUM_MODULES-1:0] LINES_IDLE = '1;

    logic                    clk;
    logic                    reset;
    logic                    spi_miso;
    logic                    spi_sclk;
    logic                    spi_cs;
    logic [`NUM_MODULES-1:0] uart_tx_line;
    logic                    shoot;
    logic                    led_red;
    logic                    led_green;
    logic                    led_blue;

    // Frames queued for the supervisor and frames actually read by the DUT
    logic [15:0] frame_q[$];
    logic [15:0] served_q[$];
    logic [15:0] cur_frame;
    int          frame_ptr;
    int          bit_pos;
    logic        cs_prev = 1'b1;
    logic        sclk_prev = 1'b0;

    logic        hold_check;
    logic        shoot_check;
    logic        shoot_q;
    logic        cs_q;
    logic        rise_seen;
    int          cycle;
    int          last_rise;
    int          cs_falls;
    int          shoot_rises;
    int          value_errs;
    int          other_errs;
    wire  [15:0] lane_count [0:`NUM_MODULES-1];

    inverter_top dut0 (
        .clk(clk), .reset(reset),
        .spi_sclk(spi_sclk), .spi_cs(spi_cs), .spi_miso(spi_miso),
        .uart_tx_line(uart_tx_line), .shoot(shoot),
        .led_red(led_red), .led_green(led_green), .led_blue(led_blue)
    );

    always #5 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        value_errs++;
        $display("ERR %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string msg);
        other_errs++;
        $display("Failure at %0t ns: %s", $time, msg);
    endtask

    // Random supervisor frames that never carry the pipe command
    task automatic make_frames(input int n);
        logic [3:0]  id;
        logic [11:0] idx;
        frame_q.delete();
        for (int f = 0; f < n; f++) begin
            id  = 4'($urandom);
            idx = 12'($urandom);
            if (idx == `PIPE_INDEX) idx = 12'h000;
            frame_q.push_back({id, idx});
        end
    endtask

    // Ten cycles of reset followed by the hold window
    task automatic apply_reset();
        @(posedge clk);
        #1 reset = 1'b1;
        @(posedge clk);
        #1 hold_check = 1'b1;
        repeat (9) @(posedge clk);
        #1 reset = 1'b0;
        repeat (`INIT_CYCLES) @(posedge clk);
        #1 hold_check = 1'b0;
    endtask

    // Byte k of a lane belongs to served frame 1 + k/2 since frame 0 is the startup read
    task automatic check_byte(input int lane, input int k, input logic [7:0] data,
                              input logic par, input logic stop);
        logic [15:0] frame;
        logic [7:0]  exp;
        logic        exp_par;
        // Parity bit makes the count of ones even
        exp_par = ($countones(data) % 2 == 1);
        assert (par === exp_par)
            else report_mismatch($sformatf("lane %0d parity", lane), par, exp_par);
        assert (stop === 1'b1)
            else report_mismatch($sformatf("lane %0d stop", lane), stop, 1'b1);
        if (served_q.size() > 1 + k / 2) begin
            frame = served_q[1 + k / 2];
            exp   = (k % 2 == 0) ? frame[15:8] : frame[7:0];
            assert (data === exp)
                else report_mismatch($sformatf("lane %0d byte %0d", lane, k), data, exp);
        end else begin
            report_failure($sformatf("lane %0d sent a byte with no frame read for it", lane));
        end
    endtask

    function automatic bit lanes_caught_up();
        int need;
        need = 2 * (served_q.size() - 1);
        if (served_q.size() < 10) return 1'b0;
        for (int i = 0; i < `NUM_MODULES; i++) begin
            if (lane_count[i] != 16'(need)) return 1'b0;
        end
        return 1'b1;
    endfunction

    // Supervisor SPI slave that shifts miso after each falling sclk
    always @(posedge clk) begin
        #1;
        if (reset) begin
            frame_ptr = 0;
            served_q.delete();
            spi_miso = 1'b1;
        end else if (cs_prev && !spi_cs) begin
            cur_frame = (frame_ptr < frame_q.size()) ? frame_q[frame_ptr] : 16'h0000;
            frame_ptr++;
            served_q.push_back(cur_frame);
            bit_pos  = 15;
            spi_miso = cur_frame[15];
        end else if (!spi_cs && sclk_prev && !spi_sclk && bit_pos > 0) begin
            bit_pos--;
            spi_miso = cur_frame[bit_pos];
        end
        cs_prev   = spi_cs;
        sclk_prev = spi_sclk;
    end

    // Idle levels during reset and the hold window
    always @(posedge clk) begin
        if (hold_check) begin
            assert (uart_tx_line === LINES_IDLE)
                else report_mismatch("uart_tx_line", uart_tx_line, LINES_IDLE);
            assert (spi_cs === 1'b1) else report_mismatch("spi_cs", spi_cs, 1'b1);
            assert (spi_sclk === 1'b0) else report_mismatch("spi_sclk", spi_sclk, 1'b0);
            assert (led_red === `LED_OFF) else report_mismatch("led_red", led_red, `LED_OFF);
            assert (led_green === `LED_OFF) else report_mismatch("led_green", led_green, `LED_OFF);
            assert (led_blue === `LED_OFF) else report_mismatch("led_blue", led_blue, `LED_OFF);
            assert (shoot === 1'b0) else report_mismatch("shoot", shoot, 1'b0);
        end
    end

    // Shoot period, pulse width and one SPI read per period
    always @(posedge clk) begin
        cycle++;
        if (!shoot_check) begin
            rise_seen   = 1'b0;
            shoot_rises = 0;
        end else begin
            if (shoot && !shoot_q) begin
                if (rise_seen) begin
                    assert (cycle - last_rise == `PERIOD_CYCLES)
                        else report_mismatch("shoot period", cycle - last_rise, `PERIOD_CYCLES);
                    assert (cs_falls == 1)
                        else report_mismatch("spi reads per period", cs_falls, 1);
                end
                rise_seen = 1'b1;
                last_rise = cycle;
                cs_falls  = 0;
                shoot_rises++;
            end
            if (!shoot && shoot_q && rise_seen) begin
                assert (cycle - last_rise == `SHOOT_CYCLES)
                    else report_mismatch("shoot width", cycle - last_rise, `SHOOT_CYCLES);
            end
            if (cs_q && !spi_cs) cs_falls++;
        end
        shoot_q = shoot;
        cs_q    = spi_cs;
    end

    // One decoder per lane sampling at mid-bit
    for (genvar i = 0; i < `NUM_MODULES; i++) begin : g_rx
        logic [7:0] data;
        logic       par;
        logic       stop;
        int         n;

        assign lane_count[i] = n[15:0];

        always begin
            @(posedge clk);
            if (reset) begin
                n = 0;
            end else if (uart_tx_line[i] === 1'b0) begin
                repeat (`BAUD_DIV / 2) @(posedge clk);
                for (int b = 0; b < 8; b++) begin
                    repeat (`BAUD_DIV) @(posedge clk);
                    data[b] = uart_tx_line[i];
                end
                repeat (`BAUD_DIV) @(posedge clk);
                par = uart_tx_line[i];
                repeat (`BAUD_DIV) @(posedge clk);
                stop = uart_tx_line[i];
                check_byte(i, n, data, par, stop);
                n++;
            end
        end
    end

    initial begin : main
        int cyc;
        bit done;
        clk         = 1'b0;
        reset       = 1'b1;
        spi_miso    = 1'b1;
        hold_check  = 1'b0;
        shoot_check = 1'b0;
        value_errs  = 0;
        other_errs  = 0;
        void'($urandom(67));
        $timeformat(-9, 0, "", 0);

        // Pipe command in the first frame
        make_frames(4);
        frame_q[0] = {`PIPE_ID, `PIPE_INDEX};
        apply_reset();
        cyc  = `INIT_CYCLES;
        done = 1'b0;
        while (!done && cyc < `MODE_WAIT_CYCLES) begin
            @(posedge clk);
            cyc++;
            assert (led_green === `LED_OFF) else report_mismatch("led_green", led_green, `LED_OFF);
            done = (led_blue === `LED_ON);
        end
        if (!done) report_failure("led_blue did not light for the pipe command");
        for (int c = 0; c < 3 * `PERIOD_CYCLES; c++) begin
            @(posedge clk);
            assert (uart_tx_line === LINES_IDLE)
                else report_mismatch("uart_tx_line", uart_tx_line, LINES_IDLE);
            assert (led_green === `LED_OFF) else report_mismatch("led_green", led_green, `LED_OFF);
        end

        // Normal mode with random frames
        make_frames(16);
        apply_reset();
        shoot_check = 1'b1;
        cyc  = `INIT_CYCLES;
        done = 1'b0;
        while (!done && cyc < `MODE_WAIT_CYCLES + 50) begin
            @(posedge clk);
            cyc++;
            assert (led_blue === `LED_OFF) else report_mismatch("led_blue", led_blue, `LED_OFF);
            done = (led_green === `LED_ON);
        end
        if (!done) begin
            report_failure("led_green did not light after the mode window");
        end else begin
            assert (cyc >= `MODE_WAIT_CYCLES)
                else report_mismatch("green delay", cyc, `MODE_WAIT_CYCLES);
        end

        cyc = 0;
        while (shoot_rises < 9 && cyc < 9 * `PERIOD_CYCLES + 100) begin
            @(posedge clk);
            cyc++;
            assert (led_blue === `LED_OFF) else report_mismatch("led_blue", led_blue, `LED_OFF);
        end
        if (shoot_rises < 9) report_failure("shoot stopped pulsing before eight periods");

        cyc = 0;
        while (!lanes_caught_up() && cyc < `PERIOD_CYCLES) begin
            @(posedge clk);
            cyc++;
        end
        if (!lanes_caught_up()) report_failure("lanes did not receive a byte pair per frame");

        $display("Closing: %0d value errors, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/inverter_top.sv */
// Multilevel inverter controller top with SPI reader, sequencer, timers and nine UART lanes
`default_nettype none

`include "inv_consts.svh"

module inverter_top (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    spi_sclk,
    output logic                    spi_cs,
    input  logic                    spi_miso,
    output logic [`NUM_MODULES-1:0] uart_tx_line,
    output logic                    shoot,
    output logic                    led_red,
    output logic                    led_green,
    output logic                    led_blue
);

    logic                    init_done;
    logic                    mode_done;
    logic [`NUM_MODULES-1:0] tx_start;
    logic [`NUM_MODULES-1:0] tx_busy;
    inv_pkg::uart_byte_t     tx_data;

    index_link_if link ();

    // Hold window and mode-select window
    interval_timer #(.COUNT(`INIT_CYCLES)) u_init_timer (
        .clk(clk), .reset(reset), .done(init_done)
    );
    interval_timer #(.COUNT(`MODE_WAIT_CYCLES)) u_mode_timer (
        .clk(clk), .reset(reset), .done(mode_done)
    );

    spi_index_reader u_reader (
        .clk(clk), .reset(reset), .link(link.reader),
        .sclk(spi_sclk), .cs(spi_cs), .miso(spi_miso)
    );

    inverter_sequencer u_seq (
        .clk(clk), .reset(reset), .link(link.requester),
        .init_done(init_done), .mode_done(mode_done),
        .tx_start(tx_start), .tx_data(tx_data), .tx_busy(tx_busy),
        .shoot(shoot), .led_green(led_green), .led_blue(led_blue)
    );

    for (genvar i = 0; i < `NUM_MODULES; i++) begin : g_lane
        uart_tx u_tx (
            .clk(clk), .reset(reset), .start(tx_start[i]), .data(tx_data),
            .line(uart_tx_line[i]), .busy(tx_busy[i])
        );
    end

    // No fault indication in this build
    assign led_red = `LED_OFF;

endmodule

`default_nettype wire

/* rtl/inverter_sequencer.sv */
// Mode select and normal-mode sequencer driving shoot and the UART index broadcast
`default_nettype none

`include "inv_consts.svh"

module inverter_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    index_link_if.requester         link,
    input  logic                    init_done,
    input  logic                    mode_done,
    output logic [`NUM_MODULES-1:0] tx_start,
    output inv_pkg::uart_byte_t     tx_data,
    input  logic [`NUM_MODULES-1:0] tx_busy,
    output logic                    shoot,
    output logic                    led_green,
    output logic                    led_blue
);

    localparam inv_pkg::period_count_t PERIOD_LAST =
        inv_pkg::period_count_t'(`PERIOD_CYCLES - 1);
    localparam inv_pkg::period_count_t SHOOT_END =
        inv_pkg::period_count_t'(`SHOOT_CYCLES);

    inv_pkg::main_state_t   state;
    inv_pkg::normal_state_t nstate;
    inv_pkg::period_count_t count;
    logic                   in_normal;
    logic                   pipe_cmd;
    logic                   send;

    assign in_normal = (state == inv_pkg::NORMAL);
    assign pipe_cmd  = link.valid && (link.index == `PIPE_INDEX) && (link.id == `PIPE_ID);

    // Free-running period counter, only in normal mode
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (in_normal) begin
            count <= (count == PERIOD_LAST) ? '0 : count + 1'b1;
        end
    end

    assign shoot = in_normal && (count < SHOOT_END);

    // Every lane gets the same byte in the same cycle
    assign send = in_normal && (nstate == inv_pkg::SEND_HIGH || nstate == inv_pkg::SEND_LOW);
    assign tx_start = {`NUM_MODULES{send}};
    assign tx_data  = (nstate == inv_pkg::SEND_LOW) ? link.index[7:0]
                                                    : {link.id, link.index[11:8]};

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= inv_pkg::INIT;
            nstate     <= inv_pkg::REQUEST;
            link.start <= 1'b0;
            led_green  <= `LED_OFF;
            led_blue   <= `LED_OFF;
        end else begin
            link.start <= 1'b0;
            case (state)
                inv_pkg::INIT: begin
                    if (init_done) begin
                        state <= inv_pkg::STARTUP;
                    end
                end
                inv_pkg::STARTUP: begin
                    link.start <= 1'b1;
                    state      <= inv_pkg::SELECT;
                end
                inv_pkg::SELECT: begin
                    if (pipe_cmd) begin
                        state    <= inv_pkg::PIPE;
                        led_blue <= `LED_ON;
                    end else if (mode_done) begin
                        // First read goes out as normal mode starts
                        state      <= inv_pkg::NORMAL;
                        nstate     <= inv_pkg::REQUEST;
                        link.start <= 1'b1;
                        led_green  <= `LED_ON;
                    end
                end
                inv_pkg::NORMAL: begin
                    case (nstate)
                        inv_pkg::REQUEST:   if (link.valid) nstate <= inv_pkg::SEND_HIGH;
                        inv_pkg::SEND_HIGH: nstate <= inv_pkg::WAIT_HIGH;
                        // Lane 0 stands for all lanes
                        inv_pkg::WAIT_HIGH: if (!tx_busy[0]) nstate <= inv_pkg::SEND_LOW;
                        inv_pkg::SEND_LOW:  nstate <= inv_pkg::WAIT_LOW;
                        inv_pkg::WAIT_LOW:  if (!tx_busy[0]) nstate <= inv_pkg::WAIT_PERIOD;
                        inv_pkg::WAIT_PERIOD: begin
                            if (count == '0) begin
                                nstate     <= inv_pkg::REQUEST;
                                link.start <= 1'b1;
                            end
                        end
                        default: nstate <= inv_pkg::REQUEST;
                    endcase
                end
                default: begin
                    // Pipe mode holds and stops the broadcast
                end
            endcase
        end
    end

    a_one_mode_led: assert property (@(posedge clk) disable iff (reset)
        !(led_green == `LED_ON && led_blue == `LED_ON))
        else $error("Both mode LEDs on");

    a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
        (|tx_start) |-> !tx_busy[0])
        else $error("tx_start pulsed while a lane is busy");

endmodule

`default_nettype wire

/* rtl/uart_tx.sv */
// UART transmitter for one byte with even parity and a busy flag
`default_nettype none

`include "inv_consts.svh"

module uart_tx (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  inv_pkg::uart_byte_t data,
    output logic                line,
    output logic                busy
);

    localparam int BW = $clog2(`BAUD_DIV + 1);
    localparam logic [BW-1:0] BAUD_LAST = BW'(`BAUD_DIV - 1);

    logic [BW-1:0] baud;
    logic [3:0]    bit_idx;
    logic          bit_end;
    // Remaining bits after the start bit: data, parity, stop
    logic [9:0]    frame;

    assign bit_end = busy && (baud == BAUD_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            line    <= 1'b1;
            baud    <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (start) begin
                busy    <= 1'b1;
                line    <= 1'b0;
                baud    <= '0;
                bit_idx <= '0;
            end
        end else if (bit_end) begin
            baud <= '0;
            // Stop bit already on the line at index 10
            if (bit_idx == 4'd10) begin
                busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
                line    <= frame[0];
            end
        end else begin
            baud <= baud + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            frame <= {1'b1, ^data, data};
        end else if (bit_end) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (reset)
        !busy |-> line)
        else $error("UART line low while idle");

endmodule

`default_nettype wire

/* rtl/spi_index_reader.sv */
// SPI master that reads one 16-bit supervisor frame and splits it into id and index
`default_nettype none

`include "inv_consts.svh"

module spi_index_reader (
    input  logic         clk,
    input  logic         reset,
    index_link_if.reader link,
    output logic         sclk,
    output logic         cs,
    input  logic         miso
);

    localparam int DW = $clog2(`SPI_HALF + 1);
    localparam logic [DW-1:0] DIV_LAST = DW'(`SPI_HALF - 1);

    logic [DW-1:0] div;
    logic [4:0]    half_cnt;
    logic          active;
    logic          finish;
    logic          load;
    logic          shift_en;
    logic [15:0]   frame;

    // Sample miso as sclk goes high
    assign shift_en = active && !finish && (div == DIV_LAST) && !sclk;

    always_ff @(posedge clk) begin
        if (reset) begin
            div        <= '0;
            half_cnt   <= '0;
            active     <= 1'b0;
            finish     <= 1'b0;
            load       <= 1'b0;
            sclk       <= 1'b0;
            cs         <= 1'b1;
            link.valid <= 1'b0;
        end else begin
            load       <= 1'b0;
            link.valid <= load;
            if (!active) begin
                if (link.start) begin
                    active   <= 1'b1;
                    cs       <= 1'b0;
                    div      <= '0;
                    half_cnt <= '0;
                end
            end else if (finish) begin
                // One idle cycle after the last falling edge, then release cs
                finish <= 1'b0;
                active <= 1'b0;
                cs     <= 1'b1;
                load   <= 1'b1;
            end else if (div == DIV_LAST) begin
                div      <= '0;
                sclk     <= ~sclk;
                half_cnt <= half_cnt + 1'b1;
                if (half_cnt == 5'd31) begin
                    finish <= 1'b1;
                end
            end else begin
                div <= div + 1'b1;
            end
        end
    end

    // MSB first, id in the top nibble
    always_ff @(posedge clk) begin
        if (shift_en) begin
            frame <= {frame[14:0], miso};
        end
        if (load) begin
            link.id    <= frame[15:12];
            link.index <= frame[11:0];
        end
    end

    a_sclk_inside_frame: assert property (@(posedge clk) disable iff (reset)
        $changed(sclk) |-> !cs)
        else $error("sclk toggled with cs high");

endmodule

`default_nettype wire

/* rtl/interval_timer.sv */
// One-shot interval timer that raises done a fixed number of cycles after reset
`default_nettype none

module interval_timer #(
    parameter int COUNT = 16
) (
    input  logic clk,
    input  logic reset,
    output logic done
);

    localparam int CW = $clog2(COUNT + 1);
    localparam logic [CW-1:0] LAST = CW'(COUNT - 1);

    logic [CW-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            done  <= 1'b0;
        end else if (!done) begin
            count <= count + 1'b1;
            // Latches high until the next reset
            if (count == LAST) begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/index_link_if.sv */
// Frame link between the SPI index reader and the sequencer
`default_nettype none

interface index_link_if;

    // One-cycle request and completion strobes
    logic start;
    logic valid;

    // Held from valid until the next frame completes
    inv_pkg::sine_index_t index;
    inv_pkg::module_id_t  id;

    modport reader (
        input  start,
        output valid,
        output index,
        output id
    );

    modport requester (
        output start,
        input  valid,
        input  index,
        input  id
    );

endinterface

`default_nettype wire

/* rtl/inv_pkg.sv */
// Shared vector types and state encodings for the inverter controller
`default_nettype none

`include "inv_consts.svh"

package inv_pkg;

    // Sine table index and target module id, as split from the SPI frame
    typedef logic [11:0] sine_index_t;
    typedef logic [3:0] module_id_t;

    // One UART payload byte
    typedef logic [7:0] uart_byte_t;

    // Holds 0 up to PERIOD_CYCLES-1
    typedef logic [$clog2(`PERIOD_CYCLES)-1:0] period_count_t;

    // Top level controller FSM
    typedef enum logic [2:0] {
        INIT,
        STARTUP,
        SELECT,
        NORMAL,
        PIPE
    } main_state_t;

    // Per-period broadcast FSM in normal mode
    typedef enum logic [2:0] {
        REQUEST,
        SEND_HIGH,
        WAIT_HIGH,
        SEND_LOW,
        WAIT_LOW,
        WAIT_PERIOD
    } normal_state_t;

endpackage

`default_nettype wire

/* rtl/inv_consts.svh */
// Inverter controller constants for timing windows, cell count and command codes
`ifndef INV_CONSTS_SVH
`define INV_CONSTS_SVH

// Number of power cells on the UART broadcast
`define NUM_MODULES 9

// Clock cycles per UART bit and per half SPI clock
`define BAUD_DIV 8
`define SPI_HALF 2

// Window lengths in clk cycles, counted from reset
`define INIT_CYCLES 40
`define MODE_WAIT_CYCLES 2000
`define PERIOD_CYCLES 1200
`define SHOOT_CYCLES 100

// Supervisor frame that commands pipe mode
`define PIPE_INDEX 12'hFFF
`define PIPE_ID 4'hA

// LEDs are active low
`define LED_ON 1'b0
`define LED_OFF 1'b1

`endif
